// ==== Makefile ====
TOP := cpuTb
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps --top-module $(TOP) -f vlog.f

run: compile
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input  logic            clk,
	input  logic            reset_n,
	input  cpuPkg::opcodeT  opcode,
	input  logic            accessDone,
	output logic            fetchReq,
	output logic            dataRead,
	output logic            dataWrite,
	output logic            irLoad,
	output logic            pcWrite,
	output logic            regWrite,
	output logic            mdrLoad,
	output logic            halted
);

	cpuPkg::ctrlStateT state;
	cpuPkg::ctrlStateT nextState;
	logic fetchPending;
	logic loadWriteback;
	logic execWrite;

	// state register and bookkeeping flags
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= cpuPkg::sFetch;
			fetchPending <= 1'b0;
			loadWriteback <= 1'b0;
		end else begin
			state <= nextState;
			// set when the fetch goes out, cleared when the word is back
			if (fetchReq) begin
				fetchPending <= 1'b1;
			end else if (accessDone) begin
				fetchPending <= 1'b0;
			end
			// loaded word reaches the register file one cycle after capture
			loadWriteback <= mdrLoad;
		end
	end

	always_comb begin
		nextState = state;
		fetchReq = 1'b0;
		dataRead = 1'b0;
		dataWrite = 1'b0;
		irLoad = 1'b0;
		pcWrite = 1'b0;
		execWrite = 1'b0;
		mdrLoad = 1'b0;
		case (state)
			cpuPkg::sFetch: begin
				fetchReq = !fetchPending;
				if (accessDone) begin
					irLoad = 1'b1;
					nextState = cpuPkg::sExecute;
				end
			end
			cpuPkg::sExecute: begin
				nextState = cpuPkg::sFetch;
				case (opcode)
					cpuPkg::opAdd, cpuPkg::opAdi, cpuPkg::opLhi: begin
						execWrite = 1'b1;
						pcWrite = 1'b1;
					end
					cpuPkg::opLwd: begin
						dataRead = 1'b1;
						pcWrite = 1'b1;
						nextState = cpuPkg::sMemory;
					end
					cpuPkg::opSwd: begin
						dataWrite = 1'b1;
						pcWrite = 1'b1;
						nextState = cpuPkg::sMemory;
					end
					cpuPkg::opHlt: begin
						nextState = cpuPkg::sHalt;
					end
					// branches, jumps and unused codes only move the pc
					default: begin
						pcWrite = 1'b1;
					end
				endcase
			end
			cpuPkg::sMemory: begin
				if (accessDone) begin
					mdrLoad = (opcode == cpuPkg::opLwd);
					nextState = cpuPkg::sFetch;
				end
			end
			cpuPkg::sHalt: begin
				nextState = cpuPkg::sHalt;
			end
			default: begin
				nextState = cpuPkg::sFetch;
			end
		endcase
	end

	assign regWrite = execWrite || loadWriteback;
	assign halted = (state == cpuPkg::sHalt);

endmodule

// ==== hw/cpuPkg.sv ====
package cpuPkg;

	// instruction opcodes, bits 15 to 12 of the instruction word
	typedef enum logic [3:0] {
		// rd = rs + rt
		opAdd = 4'd0,
		// rt = rs + sext(imm)
		opAdi = 4'd1,
		// rt = imm << 8
		opLhi = 4'd2,
		// rt = mem[rs + sext(imm)]
		opLwd = 4'd3,
		// mem[rs + sext(imm)] = rt
		opSwd = 4'd4,
		// branch when rs != rt
		opBne = 4'd5,
		// absolute jump
		opJmp = 4'd6,
		// stop until reset
		opHlt = 4'd7
	} opcodeT;

	// multicycle controller states
	typedef enum logic [1:0] {
		sFetch   = 2'd0,
		sExecute = 2'd1,
		sMemory  = 2'd2,
		sHalt    = 2'd3
	} ctrlStateT;

endpackage

// ==== hw/cpuTop.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTop (
	input  logic                   clk,
	input  logic                   reset_n,
	output logic                   readM,
	output logic                   writeM,
	output logic [`WORD_SIZE-1:0]  address,
	output logic [`WORD_SIZE-1:0]  writeData,
	input  logic [`WORD_SIZE-1:0]  readData,
	input  logic                   inputReady,
	input  logic                   ackOutput,
	output logic                   instrFetch,
	output logic                   memAccess,
	output logic                   halted
);

	logic fetchReq;
	logic dataRead;
	logic dataWrite;
	logic irLoad;
	logic pcWrite;
	logic regWrite;
	logic mdrLoad;
	logic accessDone;
	logic [`WORD_SIZE-1:0] rdWord;
	logic [`WORD_SIZE-1:0] pc;
	logic [`WORD_SIZE-1:0] effAddr;
	logic [`WORD_SIZE-1:0] storeWord;
	cpuPkg::opcodeT opcode;

	controlUnit ctrl (
		.clk(clk), .reset_n(reset_n), .opcode(opcode), .accessDone(accessDone),
		.fetchReq(fetchReq), .dataRead(dataRead), .dataWrite(dataWrite),
		.irLoad(irLoad), .pcWrite(pcWrite), .regWrite(regWrite),
		.mdrLoad(mdrLoad), .halted(halted)
	);

	datapath dp (
		.clk(clk), .reset_n(reset_n), .irLoad(irLoad), .pcWrite(pcWrite),
		.regWrite(regWrite), .mdrLoad(mdrLoad), .rdWord(rdWord), .pc(pc),
		.effAddr(effAddr), .storeWord(storeWord), .opcode(opcode)
	);

	// fetch uses the pc, loads and stores use the effective address
	memoryAccess mem (
		.clk(clk), .reset_n(reset_n), .fetchReq(fetchReq), .dataRead(dataRead),
		.dataWrite(dataWrite), .fetchAddr(pc), .dataAddr(effAddr),
		.storeWord(storeWord), .accessDone(accessDone), .rdWord(rdWord),
		.readM(readM), .writeM(writeM), .address(address), .writeData(writeData),
		.instrFetch(instrFetch), .memAccess(memAccess), .inputReady(inputReady),
		.readData(readData), .ackOutput(ackOutput)
	);

endmodule

// ==== hw/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data, instruction, register and address width
`define WORD_SIZE 16

// general registers
`define NUM_REGS 4

// bits needed to name one register
`define REG_IDX_W 2

// address bits decoded by the memory
`define MEM_ADDR_W 8

`endif

// ==== hw/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   irLoad,
	input  logic                   pcWrite,
	input  logic                   regWrite,
	input  logic                   mdrLoad,
	input  logic [`WORD_SIZE-1:0]  rdWord,
	output logic [`WORD_SIZE-1:0]  pc,
	output logic [`WORD_SIZE-1:0]  effAddr,
	output logic [`WORD_SIZE-1:0]  storeWord,
	output cpuPkg::opcodeT         opcode
);

	logic [`WORD_SIZE-1:0] ir;
	logic [`WORD_SIZE-1:0] mdr;
	logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

	logic [`REG_IDX_W-1:0] rs;
	logic [`REG_IDX_W-1:0] rt;
	logic [`REG_IDX_W-1:0] rd;
	logic [`REG_IDX_W-1:0] writeIdx;

	logic [`WORD_SIZE-1:0] rsVal;
	logic [`WORD_SIZE-1:0] rtVal;
	logic [`WORD_SIZE-1:0] immSext;
	logic [`WORD_SIZE-1:0] immHigh;
	logic [`WORD_SIZE-1:0] jumpTarget;
	logic [`WORD_SIZE-1:0] regSum;
	logic [`WORD_SIZE-1:0] immSum;
	logic [`WORD_SIZE-1:0] pcPlusOne;
	logic [`WORD_SIZE-1:0] branchTarget;
	logic [`WORD_SIZE-1:0] nextPc;
	logic [`WORD_SIZE-1:0] writeValue;
	logic branchTaken;

	// instruction fields
	assign opcode = cpuPkg::opcodeT'(ir[15:12]);
	assign rs = ir[11:10];
	assign rt = ir[9:8];
	assign rd = ir[7:6];

	// immediate forms
	assign immSext = {{8{ir[7]}}, ir[7:0]};
	assign immHigh = {ir[7:0], 8'h00};
	assign jumpTarget = {4'h0, ir[11:0]};

	assign rsVal = regs[rs];
	assign rtVal = regs[rt];

	// one adder for add, one for add immediate and addressing
	assign regSum = rsVal + rtVal;
	assign immSum = rsVal + immSext;
	assign effAddr = immSum;
	assign storeWord = rtVal;

	// next pc
	assign pcPlusOne = pc + 16'd1;
	assign branchTarget = pcPlusOne + immSext;
	assign branchTaken = (opcode == cpuPkg::opBne) && (rsVal != rtVal);

	always_comb begin
		if (opcode == cpuPkg::opJmp) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlusOne;
		end
	end

	// write-back destination and value
	always_comb begin
		writeIdx = rt;
		case (opcode)
			cpuPkg::opAdd: begin
				writeIdx = rd;
				writeValue = regSum;
			end
			cpuPkg::opAdi: writeValue = immSum;
			cpuPkg::opLhi: writeValue = immHigh;
			cpuPkg::opLwd: writeValue = mdr;
			default: writeValue = regSum;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[writeIdx] <= writeValue;
		end
	end

	// instruction and memory data registers
	always_ff @(posedge clk) begin
		if (irLoad) begin
			ir <= rdWord;
		end
		if (mdrLoad) begin
			mdr <= rdWord;
		end
	end

endmodule

// ==== hw/memoryAccess.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memoryAccess (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   fetchReq,
	input  logic                   dataRead,
	input  logic                   dataWrite,
	input  logic [`WORD_SIZE-1:0]  fetchAddr,
	input  logic [`WORD_SIZE-1:0]  dataAddr,
	input  logic [`WORD_SIZE-1:0]  storeWord,
	output logic                   accessDone,
	output logic [`WORD_SIZE-1:0]  rdWord,
	output logic                   readM,
	output logic                   writeM,
	output logic [`WORD_SIZE-1:0]  address,
	output logic [`WORD_SIZE-1:0]  writeData,
	output logic                   instrFetch,
	output logic                   memAccess,
	input  logic                   inputReady,
	input  logic [`WORD_SIZE-1:0]  readData,
	input  logic                   ackOutput
);

	logic readDone;
	logic writeDone;

	// answer only counts for the request actually on the bus
	assign readDone = readM && inputReady;
	assign writeDone = writeM && ackOutput;

	// request state, one access at a time
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readM <= 1'b0;
			writeM <= 1'b0;
			instrFetch <= 1'b0;
			memAccess <= 1'b0;
			accessDone <= 1'b0;
		end else begin
			accessDone <= readDone || writeDone;
			if (readDone || writeDone) begin
				readM <= 1'b0;
				writeM <= 1'b0;
				instrFetch <= 1'b0;
				memAccess <= 1'b0;
			end else if (fetchReq) begin
				readM <= 1'b1;
				instrFetch <= 1'b1;
			end else if (dataRead) begin
				readM <= 1'b1;
				memAccess <= 1'b1;
			end else if (dataWrite) begin
				writeM <= 1'b1;
				memAccess <= 1'b1;
			end
		end
	end

	// address and write data held for the whole access
	always_ff @(posedge clk) begin
		if (fetchReq) begin
			address <= fetchAddr;
		end else if (dataRead || dataWrite) begin
			address <= dataAddr;
		end
		if (dataWrite) begin
			writeData <= storeWord;
		end
		// returned word stays put until the next read ends
		if (readDone) begin
			rdWord <= readData;
		end
	end

endmodule

// ==== verification/cpuChecker.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuChecker (
	input logic                   clk,
	input logic                   reset_n,
	input logic                   readM,
	input logic                   writeM,
	input logic [`WORD_SIZE-1:0]  address,
	input logic [`WORD_SIZE-1:0]  writeData,
	input logic                   ackOutput,
	input logic                   inputReady,
	input logic                   instrFetch,
	input logic                   memAccess,
	input logic                   halted,
	input logic [`WORD_SIZE-1:0]  pc,
	input logic [`WORD_SIZE-1:0]  image [1 << `MEM_ADDR_W]
);

	logic [`WORD_SIZE-1:0] refMem [1 << `MEM_ADDR_W];
	logic [`WORD_SIZE-1:0] expAddr [$];
	logic [`WORD_SIZE-1:0] expData [$];
	logic [`WORD_SIZE-1:0] expFetch [$];
	logic [`WORD_SIZE-1:0] expPc;
	int expLoads = 0;
	int storeCount = 0;
	int fetchCount = 0;
	int loadCount = 0;
	int errorCount = 0;
	logic refReady = 1'b0;
	logic haltSeen = 1'b0;

	function automatic int compareValue(input string name, input logic [15:0] got,
			input logic [15:0] want);
		if (got !== want) begin
			$display("FAIL %0t: %s got %h expected %h", $time, name, got, want);
			return 1;
		end
		return 0;
	endfunction

	// instruction-set model run on a copy of the memory until halt
	function automatic void runReference();
		logic [15:0] regs [4];
		logic [15:0] pcRef;
		logic [15:0] pcNext;
		logic [15:0] instr;
		logic [15:0] imm;
		logic [15:0] addr;
		logic [1:0] rs;
		logic [1:0] rt;
		int steps;
		for (int i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		pcRef = '0;
		steps = 0;
		instr = refMem[0];
		while (instr[15:12] != 4'd7 && steps < 1000) begin
			expFetch.push_back(pcRef);
			rs = instr[11:10];
			rt = instr[9:8];
			imm = {{8{instr[7]}}, instr[7:0]};
			addr = regs[rs] + imm;
			pcNext = pcRef + 16'd1;
			case (cpuPkg::opcodeT'(instr[15:12]))
				cpuPkg::opAdd: regs[instr[7:6]] = regs[rs] + regs[rt];
				cpuPkg::opAdi: regs[rt] = regs[rs] + imm;
				cpuPkg::opLhi: regs[rt] = {instr[7:0], 8'h00};
				cpuPkg::opLwd: begin
					regs[rt] = refMem[addr[7:0]];
					expLoads++;
				end
				cpuPkg::opSwd: begin
					refMem[addr[7:0]] = regs[rt];
					expAddr.push_back(addr);
					expData.push_back(regs[rt]);
				end
				cpuPkg::opBne: begin
					if (regs[rs] != regs[rt]) begin
						pcNext = pcRef + 16'd1 + imm;
					end
				end
				cpuPkg::opJmp: pcNext = {4'h0, instr[11:0]};
				default: pcNext = pcRef + 16'd1;
			endcase
			pcRef = pcNext;
			instr = refMem[pcRef[7:0]];
			steps++;
		end
		// the halt instruction is fetched too
		expFetch.push_back(pcRef);
		expPc = pcRef;
	endfunction

	initial begin
		@(posedge reset_n);
		for (int i = 0; i < (1 << `MEM_ADDR_W); i++) begin
			refMem[i] = image[i];
		end
		runReference();
		refReady = 1'b1;
	end

	always @(posedge clk) begin
		if (reset_n && refReady) begin
			if (writeM && ackOutput) begin
				if (storeCount < expAddr.size()) begin
					errorCount += compareValue("address", address, expAddr[storeCount]);
					errorCount += compareValue("writeData", writeData, expData[storeCount]);
				end else begin
					$display("store to %h at %0t goes past the reference stores", address, $time);
					errorCount++;
				end
				storeCount++;
			end
			// fetches follow the reference pc trace
			if (readM && inputReady) begin
				if (instrFetch) begin
					if (fetchCount < expFetch.size()) begin
						errorCount += compareValue("fetch address", address,
							expFetch[fetchCount]);
					end
					fetchCount++;
				end else begin
					loadCount++;
				end
			end
			if ((readM || writeM) && (instrFetch == memAccess)) begin
				$display("access at %0t is not marked as exactly one kind", $time);
				errorCount++;
			end
			if (instrFetch) begin
				errorCount += compareValue("readM", 16'(readM), 16'd1);
			end
			if (haltSeen && (readM || writeM || !halted)) begin
				$display("bus request or halted drop at %0t after halt", $time);
				errorCount++;
			end
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				errorCount += compareValue("pc", pc, expPc);
			end
		end
	end

	// end-of-run checks called once by the testbench
	function automatic int finalCheck();
		int failures;
		failures = 0;
		if (!haltSeen) begin
			$display("halted never rose");
			failures++;
		end
		failures += compareValue("store count", 16'(storeCount), 16'(expAddr.size()));
		failures += compareValue("fetch count", 16'(fetchCount), 16'(expFetch.size()));
		failures += compareValue("load count", 16'(loadCount), 16'(expLoads));
		return failures;
	endfunction

endmodule

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTb;

	localparam int PROG_LEN = 22;
	// fetch, execute and one data access at the longest memory delay
	localparam int WORST_CYCLES = 16;
	localparam int MARGIN_CYCLES = 60;
	localparam int TIMEOUT_NS = (PROG_LEN * WORST_CYCLES + MARGIN_CYCLES) * 100;

	logic clk;
	logic reset_n;
	logic readM;
	logic writeM;
	logic [`WORD_SIZE-1:0] address;
	logic [`WORD_SIZE-1:0] writeData;
	logic [`WORD_SIZE-1:0] readData;
	logic inputReady;
	logic ackOutput;
	logic instrFetch;
	logic memAccess;
	logic halted;
	logic [`WORD_SIZE-1:0] mem [1 << `MEM_ADDR_W];
	int totalErrors;

	cpuTop dut (
		.clk(clk), .reset_n(reset_n), .readM(readM), .writeM(writeM),
		.address(address), .writeData(writeData), .readData(readData),
		.inputReady(inputReady), .ackOutput(ackOutput), .instrFetch(instrFetch),
		.memAccess(memAccess), .halted(halted)
	);

	cpuChecker chk (
		.clk(clk), .reset_n(reset_n), .readM(readM), .writeM(writeM),
		.address(address), .writeData(writeData), .ackOutput(ackOutput),
		.inputReady(inputReady), .instrFetch(instrFetch), .memAccess(memAccess),
		.halted(halted), .pc(dut.dp.pc), .image(mem)
	);

	function automatic logic [15:0] regOp(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd);
		return {4'(cpuPkg::opAdd), rs, rt, rd, 6'b0};
	endfunction

	function automatic logic [15:0] immOp(input cpuPkg::opcodeT op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {4'(op), rs, rt, imm};
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model with image setup and one answer per request after 1 to 4 cycles
	initial begin : memoryModel
		int delay;
		logic busy;
		void'($urandom(32'h15f0));
		readData = '0;
		inputReady = 1'b0;
		ackOutput = 1'b0;
		busy = 1'b0;
		delay = 0;
		for (int i = 0; i < (1 << `MEM_ADDR_W); i++) begin
			if (i >= 128) begin
				mem[i] = 16'($urandom);
			end else begin
				mem[i] = {8'(i) ^ 8'hc3, 8'(i)};
			end
		end
		mem[0] = immOp(cpuPkg::opAdi, 0, 1, 8'h05);
		mem[1] = immOp(cpuPkg::opAdi, 0, 2, 8'hfd);
		mem[2] = regOp(1, 2, 3);
		mem[3] = immOp(cpuPkg::opSwd, 0, 3, 8'h40);
		mem[4] = immOp(cpuPkg::opLhi, 0, 3, 8'h12);
		mem[5] = immOp(cpuPkg::opSwd, 0, 3, 8'h41);
		mem[6] = immOp(cpuPkg::opAdi, 0, 3, 8'h70);
		// loads from the random region at 0x80 and 0x95
		mem[7] = immOp(cpuPkg::opLwd, 3, 1, 8'h10);
		mem[8] = immOp(cpuPkg::opAdi, 1, 1, 8'h07);
		mem[9] = immOp(cpuPkg::opSwd, 0, 1, 8'h42);
		mem[10] = immOp(cpuPkg::opLwd, 3, 2, 8'h25);
		mem[11] = regOp(1, 2, 2);
		mem[12] = immOp(cpuPkg::opSwd, 0, 2, 8'h43);
		// taken branch skips 14, untaken branch runs 16, jump skips 18
		mem[13] = immOp(cpuPkg::opBne, 0, 3, 8'h01);
		mem[14] = immOp(cpuPkg::opSwd, 0, 3, 8'h50);
		mem[15] = immOp(cpuPkg::opBne, 3, 3, 8'h01);
		mem[16] = immOp(cpuPkg::opSwd, 0, 3, 8'h44);
		mem[17] = {4'(cpuPkg::opJmp), 12'd19};
		mem[18] = immOp(cpuPkg::opSwd, 0, 1, 8'h51);
		mem[19] = immOp(cpuPkg::opAdi, 0, 0, 8'h01);
		mem[20] = immOp(cpuPkg::opSwd, 0, 0, 8'h44);
		mem[21] = {4'(cpuPkg::opHlt), 12'h000};
		forever begin
			@(negedge clk);
			inputReady = 1'b0;
			ackOutput = 1'b0;
			if (!reset_n) begin
				busy = 1'b0;
			end else if (busy) begin
				delay--;
				if (delay == 0) begin
					busy = 1'b0;
					if (readM) begin
						readData = mem[address[`MEM_ADDR_W-1:0]];
						inputReady = 1'b1;
					end else begin
						mem[address[`MEM_ADDR_W-1:0]] = writeData;
						ackOutput = 1'b1;
					end
				end
			end else if (readM || writeM) begin
				busy = 1'b1;
				delay = $urandom_range(1, 4);
			end
		end
	end

	initial begin
		reset_n = 1'b0;
		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		wait (halted === 1'b1);
		// quiet window for the no-request-after-halt check
		repeat (20) @(negedge clk);
		totalErrors = chk.errorCount + chk.finalCheck() + dut.mem.props.failCount;
		$display("errors: %0d (checker %0d, assertions %0d)", totalErrors,
			chk.errorCount, dut.mem.props.failCount);
		if (totalErrors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout after %0d ns without the program reaching halt", TIMEOUT_NS);
		$display("errors: %0d (checker %0d, assertions %0d)", chk.errorCount + 1,
			chk.errorCount, dut.mem.props.failCount);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== verification/cpu_properties.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuProperties (
	input logic                   clk,
	input logic                   reset_n,
	input logic                   readM,
	input logic                   writeM,
	input logic [`WORD_SIZE-1:0]  address,
	input logic [`WORD_SIZE-1:0]  writeData,
	input logic                   inputReady,
	input logic                   ackOutput,
	input logic                   instrFetch,
	input logic                   memAccess
);

	int failCount = 0;

	// one direction at a time
	assert property (@(posedge clk) disable iff (!reset_n) !(readM && writeM))
	else begin
		failCount++;
		$error("readM and writeM asserted together");
	end

	// open request holds direction, kind, address and data until answered
	assert property (@(posedge clk) disable iff (!reset_n)
		((readM && !inputReady) || (writeM && !ackOutput)) |=>
		($stable(readM) && $stable(writeM) && $stable(instrFetch) &&
		$stable(memAccess) && $stable(address) && $stable(writeData)))
	else begin
		failCount++;
		$error("memory request changed before its answer");
	end

	// bus idle right after a reset cycle
	assert property (@(posedge clk) !reset_n |=> !(readM || writeM || instrFetch || memAccess))
	else begin
		failCount++;
		$error("memory port not idle after reset");
	end

endmodule

bind memoryAccess cpuProperties props (
	.clk(clk), .reset_n(reset_n), .readM(readM), .writeM(writeM),
	.address(address), .writeData(writeData), .inputReady(inputReady),
	.ackOutput(ackOutput), .instrFetch(instrFetch), .memAccess(memAccess)
);

// ==== vlog.f ====
+incdir+hw
hw/cpuPkg.sv
hw/memoryAccess.sv
hw/controlUnit.sv
hw/datapath.sv
hw/cpuTop.sv
verification/cpu_properties.sv
verification/cpuChecker.sv
verification/cpuTb.sv
